//--- box_order.f
+incdir+src
src/ascii_pkg.sv
src/box_pkg.sv
src/line_decoder.sv
src/box_measure.sv
src/order_totals.sv
src/box_order_top.sv
sim/box_order_sva.sv
sim/box_order_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the box order simulation with Verilator.
# Exits non-zero if the build, the run or the result check fails.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module box_order_tb \
    -f box_order.f \
    -o sim_box_order

./obj_dir/sim_box_order > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "^Result: PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1

//--- sim/box_order_sva.sv
`timescale 1ns/1ps

module box_order_sva
    import box_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic format_error,
    input logic done,
    input tot_t paper_total,
    input tot_t ribbon_total
);

    int fail_count = 0;

    // done and format_error are sticky until reset
    done_sticky: assert property (@(posedge clk) disable iff (!rst_n) done |=> done)
        else begin
            $error("done fell without a reset");
            fail_count++;
        end

    error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        format_error |=> format_error)
        else begin
            $error("format_error fell without a reset");
            fail_count++;
        end

    // totals only accumulate
    totals_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (paper_total >= $past(paper_total)) && (ribbon_total >= $past(ribbon_total)))
        else begin
            $error("a running total decreased");
            fail_count++;
        end

    outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({format_error, done, paper_total, ribbon_total}))
        else begin
            $error("an output is unknown after reset");
            fail_count++;
        end

endmodule

bind box_order_top box_order_sva sva_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .format_error (format_error),
    .done         (done),
    .paper_total  (paper_total),
    .ribbon_total (ribbon_total)
);

//--- sim/box_order_tb.sv
`timescale 1ns/1ps

module box_order_tb
    import ascii_pkg::*;
    import box_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int MAX_GAP      = 3;
    // bytes sent over all tests, rounded up
    localparam int TEST_BYTES   = 120;
    localparam int MARGIN_CYCLES = 400;

    logic  clk;
    logic  rst_n;
    logic  byte_valid;
    char_t byte_data;
    logic  format_error;
    tot_t  paper_total;
    tot_t  ribbon_total;
    logic  done;

    int     errors = 0;
    integer seed = 42;
    bit     use_gaps = 0;
    tot_t   ref_paper;
    tot_t   ref_ribbon;
    tot_t   saved_paper;
    tot_t   saved_ribbon;

    box_order_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .format_error (format_error),
        .paper_total  (paper_total),
        .ribbon_total (ribbon_total),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // each byte may take up to MAX_GAP idle cycles on top of its own
    initial begin
        #(CLK_PERIOD * (TEST_BYTES * (MAX_GAP + 1) + MARGIN_CYCLES));
        $display("timeout: the tests did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    task automatic check_total(input string name, input tot_t expected, input tot_t actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    // sort the sides, then smallest face and perimeter come from the two shortest
    task automatic add_reference(input longint l, input longint w, input longint h);
        longint a;
        longint b;
        longint c;
        longint t;
        a = l;
        b = w;
        c = h;
        if (a > b) begin
            t = a;
            a = b;
            b = t;
        end
        if (b > c) begin
            t = b;
            b = c;
            c = t;
        end
        if (a > b) begin
            t = a;
            a = b;
            b = t;
        end
        ref_paper  += tot_t'(2 * (l * w + w * h + h * l) + a * b);
        ref_ribbon += tot_t'(2 * (a + b) + l * w * h);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic reset_dut();
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n      = 1'b1;
        ref_paper  = '0;
        ref_ribbon = '0;
    endtask

    task automatic drive_byte(input byte b);
        int idle;
        byte_valid = 1'b1;
        byte_data  = char_t'(b);
        @(posedge clk);
        #2;
        byte_valid = 1'b0;
        if (use_gaps) begin
            idle = {$random(seed)} % (MAX_GAP + 1);
            repeat (idle) begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            drive_byte(s[i]);
        end
    endtask

    task automatic send_line(input string s, input int l, input int w, input int h);
        send_text(s);
        add_reference(l, w, h);
    endtask

    task automatic test_single_box();
        reset_dut();
        send_line("2x3x4\n", 2, 3, 4);
        wait_cycles(4);
        check_total("single box paper", 48'd58, paper_total);
        check_total("single box ribbon", 48'd34, ribbon_total);
        check_total("single box paper ref", ref_paper, paper_total);
        check_total("single box ribbon ref", ref_ribbon, ribbon_total);
        check_flag("single box format_error", 1'b0, format_error);
    endtask

    task automatic send_multi_lines();
        send_line("20x3x11\n", 20, 3, 11);
        send_line("123x45x6\n", 123, 45, 6);
        send_line("4095x17x250\n", 4095, 17, 250);
    endtask

    task automatic test_multi_digit();
        reset_dut();
        send_multi_lines();
        wait_cycles(4);
        check_total("multi digit paper", ref_paper, paper_total);
        check_total("multi digit ribbon", ref_ribbon, ribbon_total);
        saved_paper  = paper_total;
        saved_ribbon = ribbon_total;
    endtask

    task automatic test_idle_gaps();
        reset_dut();
        use_gaps = 1;
        send_multi_lines();
        use_gaps = 0;
        wait_cycles(4);
        check_total("idle gaps paper", saved_paper, paper_total);
        check_total("idle gaps ribbon", saved_ribbon, ribbon_total);
        check_total("idle gaps paper ref", ref_paper, paper_total);
        check_total("idle gaps ribbon ref", ref_ribbon, ribbon_total);
    endtask

    task automatic test_end_of_order();
        tot_t p;
        tot_t r;
        reset_dut();
        send_line("1x1x10\n", 1, 1, 10);
        send_line("4x5x6\n", 4, 5, 6);
        send_text("\n");
        check_flag("end of order done early", 1'b0, done);
        wait_cycles(4);
        check_flag("end of order done", 1'b1, done);
        check_total("end of order paper", ref_paper, paper_total);
        check_total("end of order ribbon", ref_ribbon, ribbon_total);
        p = paper_total;
        r = ribbon_total;
        wait_cycles(8);
        check_total("end of order paper stable", p, paper_total);
        check_total("end of order ribbon stable", r, ribbon_total);
        check_flag("end of order format_error", 1'b0, format_error);
    endtask

    task automatic test_format_error();
        reset_dut();
        // comma inside the first field does not split the number
        send_line("4,x5x6\n", 4, 5, 6);
        check_flag("format error raised", 1'b1, format_error);
        send_line("7x8x9\n", 7, 8, 9);
        wait_cycles(4);
        check_flag("format error sticky", 1'b1, format_error);
        check_total("format error paper", ref_paper, paper_total);
        check_total("format error ribbon", ref_ribbon, ribbon_total);
    endtask

    task automatic test_reset_mid_order();
        reset_dut();
        send_line("3x3x3\n", 3, 3, 3);
        send_text("%");
        send_text("\n");
        wait_cycles(4);
        check_flag("before reset done", 1'b1, done);
        check_flag("before reset format_error", 1'b1, format_error);
        send_text("5x6");
        reset_dut();
        check_total("after reset paper", '0, paper_total);
        check_total("after reset ribbon", '0, ribbon_total);
        check_flag("after reset done", 1'b0, done);
        check_flag("after reset format_error", 1'b0, format_error);
        send_line("2x3x4\n", 2, 3, 4);
        send_line("1x1x1\n", 1, 1, 1);
        wait_cycles(4);
        check_total("new order paper", ref_paper, paper_total);
        check_total("new order ribbon", ref_ribbon, ribbon_total);
    endtask

    initial begin
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        byte_data  = LF_CHAR;

        test_single_box();
        test_multi_digit();
        test_idle_gaps();
        test_end_of_order();
        test_format_error();
        test_reset_mid_order();
        wait_cycles(2);

        $display("errors: %0d, assertion failures: %0d", errors, dut_i.sva_i.fail_count);
        if (errors == 0 && dut_i.sva_i.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src/ascii_pkg.sv
package ascii_pkg;

    // the only byte values the decoder acts on
    typedef enum logic [7:0] {
        LF_CHAR   = 8'h0A,
        ZERO_CHAR = 8'h30,
        NINE_CHAR = 8'h39,
        X_CHAR    = 8'h78
    } char_t;

    // field that the next digits belong to
    typedef enum logic [1:0] {
        FIELD_LENGTH = 2'd0,
        FIELD_WIDTH  = 2'd1,
        FIELD_HEIGHT = 2'd2
    } field_t;

endpackage

//--- src/box_measure.sv
`timescale 1ns/1ps
`default_nettype none
`include "box_order_defs.svh"

module box_measure
    import box_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic size_valid,
    input  dim_t length,
    input  dim_t width,
    input  dim_t height,
    output logic result_valid,
    output res_t paper,
    output res_t ribbon
);

    logic [2*`BOX_DIM_W-1:0] area_lw_q;
    logic [2*`BOX_DIM_W-1:0] area_wh_q;
    logic [2*`BOX_DIM_W-1:0] area_hl_q;
    logic [3*`BOX_DIM_W-1:0] vol_q;
    logic [`BOX_DIM_W:0]     pair_q;
    logic                    v1_q;

    dim_t                    largest;
    logic [`BOX_DIM_W:0]     pair_sum;
    logic [2*`BOX_DIM_W-1:0] min_area;
    res_t                    area_sum;

    res_t                    paper_q;
    res_t                    ribbon_q;
    logic                    v2_q;

    // two smallest dimensions are the total minus the largest
    always_comb begin
        largest = length;
        if (width > largest) begin
            largest = width;
        end
        if (height > largest) begin
            largest = height;
        end
        pair_sum = length + width + height - largest;
    end

    // stage one
    always_ff @(posedge clk) begin
        area_lw_q <= length * width;
        area_wh_q <= width * height;
        area_hl_q <= height * length;
        vol_q     <= length * width * height;
        pair_q    <= pair_sum;
    end

    always_comb begin
        min_area = area_lw_q;
        if (area_wh_q < min_area) begin
            min_area = area_wh_q;
        end
        if (area_hl_q < min_area) begin
            min_area = area_hl_q;
        end
        area_sum = res_t'(area_lw_q) + res_t'(area_wh_q) + res_t'(area_hl_q);
    end

    // stage two
    always_ff @(posedge clk) begin
        paper_q  <= (area_sum << 1) + res_t'(min_area);
        ribbon_q <= res_t'(vol_q) + (res_t'(pair_q) << 1);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= size_valid;
            v2_q <= v1_q;
        end
    end

    assign result_valid = v2_q;
    assign paper        = paper_q;
    assign ribbon       = ribbon_q;

endmodule

`default_nettype wire

//--- src/box_order_defs.svh
`ifndef BOX_ORDER_DEFS_SVH
`define BOX_ORDER_DEFS_SVH

// width of one decoded dimension
// digits beyond this wrap modulo 2**12
`define BOX_DIM_W 12

// per-box paper or ribbon value
// a 36-bit volume plus the perimeter fits with room to spare
`define BOX_RES_W 40

// running totals over the whole order
`define BOX_TOT_W 48

`endif

//--- src/box_order_top.sv
`timescale 1ns/1ps
`default_nettype none

module box_order_top
    import ascii_pkg::*;
    import box_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  byte_valid,
    input  char_t byte_data,
    output logic  format_error,
    output tot_t  paper_total,
    output tot_t  ribbon_total,
    output logic  done
);

    logic size_valid;
    dim_t length;
    dim_t width;
    dim_t height;
    logic end_of_input;
    logic result_valid;
    res_t paper;
    res_t ribbon;

    line_decoder u_line_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .size_valid   (size_valid),
        .length       (length),
        .width        (width),
        .height       (height),
        .end_of_input (end_of_input),
        .format_error (format_error)
    );

    box_measure u_box_measure (
        .clk          (clk),
        .rst_n        (rst_n),
        .size_valid   (size_valid),
        .length       (length),
        .width        (width),
        .height       (height),
        .result_valid (result_valid),
        .paper        (paper),
        .ribbon       (ribbon)
    );

    order_totals u_order_totals (
        .clk          (clk),
        .rst_n        (rst_n),
        .result_valid (result_valid),
        .paper        (paper),
        .ribbon       (ribbon),
        .end_of_input (end_of_input),
        .paper_total  (paper_total),
        .ribbon_total (ribbon_total),
        .done         (done)
    );

endmodule

`default_nettype wire

//--- src/box_pkg.sv
`include "box_order_defs.svh"

package box_pkg;

    // one decoded dimension of a box
    typedef logic [`BOX_DIM_W-1:0] dim_t;

    // paper or ribbon for a single box
    typedef logic [`BOX_RES_W-1:0] res_t;

    // accumulated paper or ribbon for the order
    typedef logic [`BOX_TOT_W-1:0] tot_t;

endpackage

//--- src/line_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "box_order_defs.svh"

module line_decoder
    import ascii_pkg::*;
    import box_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   byte_valid,
    input  char_t  byte_data,
    output logic   size_valid,
    output dim_t   length,
    output dim_t   width,
    output dim_t   height,
    output logic   end_of_input,
    output logic   format_error
);

    char_t  prev_byte;
    field_t field;
    dim_t   acc;
    dim_t   length_q;
    dim_t   width_q;
    dim_t   height_q;
    logic   size_valid_q;
    logic   end_q;
    logic   error_q;
    logic   is_digit;
    logic   is_x;
    logic   is_lf;
    logic   prev_digit;
    dim_t   digit;

    always_comb begin
        is_digit   = (byte_data >= ZERO_CHAR) && (byte_data <= NINE_CHAR);
        is_x       = (byte_data == X_CHAR);
        is_lf      = (byte_data == LF_CHAR);
        prev_digit = (prev_byte >= ZERO_CHAR) && (prev_byte <= NINE_CHAR);
        digit      = `BOX_DIM_W'(byte_data - ZERO_CHAR);
    end

    // start of stream counts as the start of a line, so a leading LF ends the order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_byte    <= LF_CHAR;
            field        <= FIELD_LENGTH;
            size_valid_q <= 1'b0;
            end_q        <= 1'b0;
            error_q      <= 1'b0;
        end else begin
            size_valid_q <= 1'b0;
            if (byte_valid) begin
                // unknown bytes leave prev_byte alone so they do not split a number
                if (is_digit || is_x || is_lf) begin
                    prev_byte <= byte_data;
                end else begin
                    error_q <= 1'b1;
                end
                if (is_x) begin
                    case (field)
                        FIELD_LENGTH: field <= FIELD_WIDTH;
                        default:      field <= FIELD_HEIGHT;
                    endcase
                end else if (is_lf) begin
                    field <= FIELD_LENGTH;
                    if (prev_byte == LF_CHAR) begin
                        end_q <= 1'b1;
                    end else begin
                        size_valid_q <= 1'b1;
                    end
                end
            end
        end
    end

    // decimal accumulator and captured fields
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (is_digit) begin
                acc <= prev_digit ? (acc * 4'd10 + digit) : digit;
            end
            if (is_x && (field == FIELD_LENGTH)) begin
                length_q <= acc;
            end
            if (is_x && (field == FIELD_WIDTH)) begin
                width_q <= acc;
            end
            if (is_lf) begin
                height_q <= acc;
            end
        end
    end

    assign size_valid   = size_valid_q;
    assign length       = length_q;
    assign width        = width_q;
    assign height       = height_q;
    assign end_of_input = end_q;
    assign format_error = error_q;

endmodule

`default_nettype wire

//--- src/order_totals.sv
`timescale 1ns/1ps
`default_nettype none

module order_totals
    import box_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic result_valid,
    input  res_t paper,
    input  res_t ribbon,
    input  logic end_of_input,
    output tot_t paper_total,
    output tot_t ribbon_total,
    output logic done
);

    tot_t       paper_acc;
    tot_t       ribbon_acc;
    logic [2:0] eoi_shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paper_acc  <= '0;
            ribbon_acc <= '0;
        end else if (result_valid) begin
            paper_acc  <= paper_acc + tot_t'(paper);
            ribbon_acc <= ribbon_acc + tot_t'(ribbon);
        end
    end

    // three stages cover the decoder-to-totals latency of the last box
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eoi_shift <= 3'b000;
        end else begin
            eoi_shift <= {eoi_shift[1:0], end_of_input};
        end
    end

    assign paper_total  = paper_acc;
    assign ribbon_total = ribbon_acc;
    assign done         = eoi_shift[2];

endmodule

`default_nettype wire
